/* hw/motion_pkg.sv */
// motion subsystem shared definitions

package motion_pkg;

    // channel counts, channels are always generated
    localparam int NOS_QE_CHANNELS  = 2;
    localparam int NOS_PWM_CHANNELS = 2;

    // upper address nibble selects the register group
    localparam logic [3:0] GROUP_SYS = 4'h0;
    localparam logic [3:0] GROUP_QE  = 4'h1;
    localparam logic [3:0] GROUP_PWM = 4'h2;

    // identity word returned at address 0x00
    localparam logic [31:0] SYS_ID = 32'h4d53_0202;

    // encoder register numbers, address bits 1..0
    localparam logic [1:0] QE_REG_COUNT = 2'd0;
    localparam logic [1:0] QE_REG_INDEX = 2'd1;

    // pwm register numbers
    localparam logic [1:0] PWM_REG_PERIOD  = 2'd0;
    localparam logic [1:0] PWM_REG_ON_TIME = 2'd1;
    localparam logic [1:0] PWM_REG_CONTROL = 2'd2;

    // host link byte
    typedef logic [7:0] up_byte_t;

    // [7:4] group, [3:2] channel, [1:0] register
    typedef logic [7:0] reg_addr_t;

    // internal bus word
    typedef logic [31:0] reg_data_t;

    // host link controller states
    typedef enum logic [2:0] {
        IDLE,
        ADDR_WAIT,
        ADDR_DONE,
        FETCH,
        DATA_WAIT,
        DATA_DONE,
        COMMIT,
        ACK
    } link_state_t;

endpackage

/* hw/synchronizer.sv */
// two flop input synchronizer
`timescale 1ns/1ps

module synchronizer (
    input  logic clk,
    input  logic rst_n,
    input  logic async_in,
    output logic sync_out
);

    // first stage, may go metastable
    logic meta;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta     <= 1'b0;
            sync_out <= 1'b0;
        end else begin
            meta     <= async_in;
            // second stage settles the level
            sync_out <= meta;
        end
    end

endmodule

/* hw/up_interface.sv */
// host link controller
`timescale 1ns/1ps

module up_interface (
    input  logic                                            clk,
    input  logic                                            rst_n,
    // host controls, already synchronized
    input  logic                                            up_start,
    input  logic                                            up_rw,
    input  logic                                            up_handshake_1,
    // host data byte, split by direction
    input  motion_pkg::up_byte_t                            uP_data_in,
    output motion_pkg::up_byte_t                            uP_data_out,
    output logic                                            uP_data_oe,
    output logic                                            uP_handshake_2,
    output logic                                            uP_ack,
    output logic                                            uP_nFault,
    // internal register bus
    output motion_pkg::reg_addr_t                           reg_addr,
    output motion_pkg::reg_data_t                           reg_wdata,
    output logic                                            reg_write,
    output logic                                            reg_read,
    // per channel hit and read words
    input  logic [motion_pkg::NOS_QE_CHANNELS-1:0]          qe_hit,
    input  motion_pkg::reg_data_t [motion_pkg::NOS_QE_CHANNELS-1:0]  qe_rdata,
    input  logic [motion_pkg::NOS_PWM_CHANNELS-1:0]         pwm_hit,
    input  motion_pkg::reg_data_t [motion_pkg::NOS_PWM_CHANNELS-1:0] pwm_rdata
);
    import motion_pkg::*;

    link_state_t state;
    // previous up_start, for the rising edge
    logic        start_d;
    // data byte number, 0..3
    logic [1:0]  byte_cnt;
    // read word, shifted out low byte first
    reg_data_t   rd_buf;
    reg_data_t   rd_word;
    logic        any_hit;
    logic        sys_hit;
    logic        addr_fault;

    // address 0x00 is the identity register, held here
    assign sys_hit = (reg_addr[7:4] == GROUP_SYS) && (reg_addr[3:0] == 4'h0);
    assign any_hit = (|qe_hit) | (|pwm_hit);

    // reads may also hit the identity word, writes only a channel
    assign addr_fault = up_rw ? !(any_hit || sys_hit) : !any_hit;

    // channels drive zero unless addressed, so a plain OR merges them
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < NOS_QE_CHANNELS; i++) begin
            rd_word = rd_word | qe_rdata[i];
        end
        for (int j = 0; j < NOS_PWM_CHANNELS; j++) begin
            rd_word = rd_word | pwm_rdata[j];
        end
        if (sys_hit) begin
            rd_word = SYS_ID;
        end
    end

    // strobes straight from state
    assign reg_read    = (state == FETCH) && up_rw;
    // faulted writes never reach a register
    assign reg_write   = (state == COMMIT) && uP_nFault;
    assign uP_ack      = (state == ACK);
    assign uP_data_out = rd_buf[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            start_d        <= 1'b0;
            byte_cnt       <= 2'd0;
            rd_buf         <= '0;
            reg_addr       <= '0;
            reg_wdata      <= '0;
            uP_handshake_2 <= 1'b0;
            uP_data_oe     <= 1'b0;
            uP_nFault      <= 1'b1;
        end else begin
            start_d <= up_start;
            case (state)
                IDLE: begin
                    // new transaction clears any old fault
                    if (up_start && !start_d) begin
                        uP_nFault <= 1'b1;
                        state     <= ADDR_WAIT;
                    end
                end
                ADDR_WAIT: begin
                    // first byte is always the address, host to us
                    if (up_handshake_1) begin
                        reg_addr       <= uP_data_in;
                        uP_handshake_2 <= 1'b1;
                        state          <= ADDR_DONE;
                    end
                end
                ADDR_DONE: begin
                    if (!up_handshake_1) begin
                        uP_handshake_2 <= 1'b0;
                        state          <= FETCH;
                    end
                end
                FETCH: begin
                    // single cycle, read word captured with reg_read
                    byte_cnt <= 2'd0;
                    rd_buf   <= addr_fault ? '0 : rd_word;
                    if (addr_fault) begin
                        uP_nFault <= 1'b0;
                    end
                    state <= DATA_WAIT;
                end
                DATA_WAIT: begin
                    if (up_handshake_1) begin
                        if (up_rw) begin
                            uP_data_oe <= 1'b1;
                        end else begin
                            // low byte arrives first, shift in from the top
                            reg_wdata <= {uP_data_in, reg_wdata[31:8]};
                        end
                        uP_handshake_2 <= 1'b1;
                        state          <= DATA_DONE;
                    end
                end
                DATA_DONE: begin
                    if (!up_handshake_1) begin
                        uP_handshake_2 <= 1'b0;
                        uP_data_oe     <= 1'b0;
                        rd_buf         <= rd_buf >> 8;
                        byte_cnt       <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            state <= up_rw ? ACK : COMMIT;
                        end else begin
                            state <= DATA_WAIT;
                        end
                    end
                end
                COMMIT: begin
                    // reg_write pulses here
                    state <= ACK;
                end
                ACK: begin
                    // hold ack until host drops start
                    if (!up_start) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/qe_channel.sv */
// quadrature encoder channel
`timescale 1ns/1ps

module qe_channel #(
    parameter int UNIT = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // raw encoder pins
    input  logic                  async_qe_a,
    input  logic                  async_qe_b,
    input  logic                  async_qe_i,
    // register bus slice
    input  motion_pkg::reg_addr_t reg_addr,
    input  motion_pkg::reg_data_t reg_wdata,
    input  logic                  reg_write,
    // reads have no side effect here, kept for a uniform bus
    input  logic                  reg_read,
    output logic                  hit,
    output motion_pkg::reg_data_t rdata
);
    import motion_pkg::*;

    logic      qe_a, qe_b, qe_i;
    // edge detect history
    logic      qe_a_d, qe_b_d, qe_i_d;
    logic      a_chg, b_chg;
    logic      step, step_up;
    logic      index_rise;
    reg_data_t position;
    reg_data_t index_count;

    synchronizer sync_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .async_in (async_qe_a),
        .sync_out (qe_a)
    );

    synchronizer sync_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .async_in (async_qe_b),
        .sync_out (qe_b)
    );

    synchronizer sync_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .async_in (async_qe_i),
        .sync_out (qe_i)
    );

    // x4 decode, one edge of either input is one count
    assign a_chg   = qe_a ^ qe_a_d;
    assign b_chg   = qe_b ^ qe_b_d;
    // both moving together is a glitch, no count
    assign step    = a_chg ^ b_chg;
    assign step_up = qe_a_d ^ qe_b;

    assign index_rise = qe_i & ~qe_i_d;

    // group, channel, then register 0 or 1
    assign hit = (reg_addr[7:4] == GROUP_QE) &&
                 (reg_addr[3:2] == 2'(UNIT)) &&
                 ((reg_addr[1:0] == QE_REG_COUNT) || (reg_addr[1:0] == QE_REG_INDEX));

    always_comb begin
        rdata = '0;
        if (hit) begin
            rdata = (reg_addr[1:0] == QE_REG_COUNT) ? position : index_count;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qe_a_d      <= 1'b0;
            qe_b_d      <= 1'b0;
            qe_i_d      <= 1'b0;
            position    <= '0;
            index_count <= '0;
        end else begin
            qe_a_d <= qe_a;
            qe_b_d <= qe_b;
            qe_i_d <= qe_i;
            // host load wins over a step in the same cycle
            if (reg_write && hit && (reg_addr[1:0] == QE_REG_COUNT)) begin
                position <= reg_wdata;
            end else if (step) begin
                position <= step_up ? position + 32'd1 : position - 32'd1;
            end
            // any write to the index register clears it
            if (reg_write && hit && (reg_addr[1:0] == QE_REG_INDEX)) begin
                index_count <= '0;
            end else if (index_rise) begin
                index_count <= index_count + 32'd1;
            end
        end
    end

endmodule

/* hw/pwm_channel.sv */
// pwm and h-bridge channel
`timescale 1ns/1ps

module pwm_channel #(
    parameter int UNIT = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // register bus slice
    input  motion_pkg::reg_addr_t reg_addr,
    input  motion_pkg::reg_data_t reg_wdata,
    input  logic                  reg_write,
    output logic                  hit,
    output motion_pkg::reg_data_t rdata,
    // drive outputs
    output logic                  pwm_signal,
    output logic                  h_bridge_1,
    output logic                  h_bridge_2
);
    import motion_pkg::*;

    logic [15:0] period;
    logic [15:0] on_time;
    // bit 0 enable, bit 1 direction
    logic [1:0]  control;
    logic [15:0] counter;
    logic        enable;
    logic        direction;
    logic        reg_wr;

    assign enable    = control[0];
    assign direction = control[1];

    // registers 0..2, register 3 is unmapped
    assign hit = (reg_addr[7:4] == GROUP_PWM) &&
                 (reg_addr[3:2] == 2'(UNIT)) &&
                 (reg_addr[1:0] != 2'd3);

    assign reg_wr = reg_write && hit;

    // zero-extended readback
    always_comb begin
        rdata = '0;
        if (hit) begin
            case (reg_addr[1:0])
                PWM_REG_PERIOD:  rdata = {16'h0, period};
                PWM_REG_ON_TIME: rdata = {16'h0, on_time};
                PWM_REG_CONTROL: rdata = {30'h0, control};
                default:         rdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period     <= '0;
            on_time    <= '0;
            control    <= '0;
            counter    <= '0;
            pwm_signal <= 1'b0;
            h_bridge_1 <= 1'b0;
            h_bridge_2 <= 1'b0;
        end else begin
            if (reg_wr && (reg_addr[1:0] == PWM_REG_PERIOD)) begin
                period <= reg_wdata[15:0];
            end
            if (reg_wr && (reg_addr[1:0] == PWM_REG_ON_TIME)) begin
                on_time <= reg_wdata[15:0];
            end
            if (reg_wr && (reg_addr[1:0] == PWM_REG_CONTROL)) begin
                control <= reg_wdata[1:0];
            end
            // 0 to period-1, also catches a period cut below the count
            if ((period == 16'd0) || (counter >= period - 16'd1)) begin
                counter <= '0;
            end else begin
                counter <= counter + 16'd1;
            end
            // zero period keeps the line low
            pwm_signal <= enable && (period != 16'd0) && (counter < on_time);
            h_bridge_1 <= enable && !direction;
            h_bridge_2 <= enable && direction;
        end
    end

endmodule

/* hw/motion_system.sv */
// motion control top level
`timescale 1ns/1ps

module motion_system (
    input  logic                                     CLOCK_50,
    input  logic                                     rst_n,
    // host link pins
    input  logic                                     async_up_start,
    input  logic                                     async_up_rw,
    input  logic                                     async_up_handshake_1,
    input  motion_pkg::up_byte_t                     uP_data_in,
    output motion_pkg::up_byte_t                     uP_data_out,
    output logic                                     uP_data_oe,
    output logic                                     uP_ack,
    output logic                                     uP_handshake_2,
    output logic                                     uP_nFault,
    // encoder inputs
    input  logic [motion_pkg::NOS_QE_CHANNELS-1:0]   quadrature_a,
    input  logic [motion_pkg::NOS_QE_CHANNELS-1:0]   quadrature_b,
    input  logic [motion_pkg::NOS_QE_CHANNELS-1:0]   quadrature_i,
    // motor drive outputs
    output logic [motion_pkg::NOS_PWM_CHANNELS-1:0]  pwm_out,
    output logic [motion_pkg::NOS_PWM_CHANNELS-1:0]  h_bridge_1,
    output logic [motion_pkg::NOS_PWM_CHANNELS-1:0]  h_bridge_2
);
    import motion_pkg::*;

    logic up_start, up_rw, up_handshake_1;

    // shared register bus
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    logic      reg_write, reg_read;

    // gathered channel replies
    logic      [NOS_QE_CHANNELS-1:0]  qe_hit;
    reg_data_t [NOS_QE_CHANNELS-1:0]  qe_rdata;
    logic      [NOS_PWM_CHANNELS-1:0] pwm_hit;
    reg_data_t [NOS_PWM_CHANNELS-1:0] pwm_rdata;

    // host control lines cross into CLOCK_50
    synchronizer sync_start (
        .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_up_start), .sync_out(up_start)
    );

    synchronizer sync_rw (
        .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_up_rw), .sync_out(up_rw)
    );

    synchronizer sync_handshake_1 (
        .clk(CLOCK_50), .rst_n(rst_n), .async_in(async_up_handshake_1),
        .sync_out(up_handshake_1)
    );

    // bus master
    up_interface up_interface_sys (
        .clk(CLOCK_50), .rst_n(rst_n),
        .up_start(up_start), .up_rw(up_rw), .up_handshake_1(up_handshake_1),
        .uP_data_in(uP_data_in), .uP_data_out(uP_data_out), .uP_data_oe(uP_data_oe),
        .uP_handshake_2(uP_handshake_2), .uP_ack(uP_ack), .uP_nFault(uP_nFault),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .reg_write(reg_write), .reg_read(reg_read),
        .qe_hit(qe_hit), .qe_rdata(qe_rdata),
        .pwm_hit(pwm_hit), .pwm_rdata(pwm_rdata)
    );

    // one encoder per channel slot
    for (genvar q = 0; q < NOS_QE_CHANNELS; q++) begin : qe_encoder
        qe_channel #(.UNIT(q)) qe_ch (
            .clk(CLOCK_50), .rst_n(rst_n),
            .async_qe_a(quadrature_a[q]), .async_qe_b(quadrature_b[q]),
            .async_qe_i(quadrature_i[q]),
            .reg_addr(reg_addr), .reg_wdata(reg_wdata),
            .reg_write(reg_write), .reg_read(reg_read),
            .hit(qe_hit[q]), .rdata(qe_rdata[q])
        );
    end

    // pwm channels with their bridge pairs
    for (genvar p = 0; p < NOS_PWM_CHANNELS; p++) begin : pwm_h_bridge
        pwm_channel #(.UNIT(p)) pwm_ch (
            .clk(CLOCK_50), .rst_n(rst_n),
            .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_write(reg_write),
            .hit(pwm_hit[p]), .rdata(pwm_rdata[p]),
            .pwm_signal(pwm_out[p]),
            .h_bridge_1(h_bridge_1[p]), .h_bridge_2(h_bridge_2[p])
        );
    end

endmodule

/* verification/motion_tasks.svh */
// host link and check tasks

// mismatch and timeout tallies
int error_count = 0;
int timeout_count = 0;

// cycles allowed for any single handshake edge
localparam int LINK_TIMEOUT = 64;

// step to 1 ns past the next rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic check_data(input string name, input reg_data_t expected,
                          input reg_data_t actual);
    if (actual !== expected) begin
        $display("** Error: %s expected %h got %h", name, expected, actual);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("** Error: %s expected %h got %h", name, expected, actual);
        error_count++;
    end
endtask

// poll uP_handshake_2 for a level
task automatic wait_handshake(input logic level);
    int n;
    n = 0;
    while ((uP_handshake_2 !== level) && (n < LINK_TIMEOUT)) begin
        next_cycle();
        n++;
    end
    if (uP_handshake_2 !== level) begin
        $display("timeout waiting for uP_handshake_2 to reach %0d", level);
        timeout_count++;
    end
endtask

// poll uP_ack for a level
task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while ((uP_ack !== level) && (n < LINK_TIMEOUT)) begin
        next_cycle();
        n++;
    end
    if (uP_ack !== level) begin
        $display("timeout waiting for uP_ack to reach %0d", level);
        timeout_count++;
    end
endtask

// one four-phase byte on the host link
task automatic link_byte(input logic reading, input up_byte_t wr_byte,
                         output up_byte_t rd_byte);
    uP_data_in = wr_byte;
    async_up_handshake_1 = 1'b1;
    wait_handshake(1'b1);
    // read byte is valid while handshake_2 is high
    rd_byte = uP_data_out;
    // data pin is driven only for read bytes
    check_bit("uP_data_oe", reading, uP_data_oe);
    async_up_handshake_1 = 1'b0;
    wait_handshake(1'b0);
    check_bit("uP_data_oe", 1'b0, uP_data_oe);
endtask

// start plus the address byte
task automatic open_link(input logic rw, input reg_addr_t addr);
    up_byte_t unused;
    async_up_rw = rw;
    async_up_start = 1'b1;
    link_byte(1'b0, addr, unused);
endtask

// wait for ack, drop start and wait for ack to fall
task automatic close_link();
    wait_ack(1'b1);
    async_up_start = 1'b0;
    wait_ack(1'b0);
endtask

task automatic host_write(input reg_addr_t addr, input reg_data_t data);
    up_byte_t unused;
    open_link(1'b0, addr);
    // low byte first
    for (int k = 0; k < 4; k++) begin
        link_byte(1'b0, data[8*k +: 8], unused);
    end
    close_link();
endtask

task automatic host_read(input reg_addr_t addr, output reg_data_t data);
    up_byte_t rd_byte;
    open_link(1'b1, addr);
    for (int k = 0; k < 4; k++) begin
        link_byte(1'b1, 8'h00, rd_byte);
        data[8*k +: 8] = rd_byte;
    end
    close_link();
endtask

/* verification/motion_system_tb.sv */
// motion system testbench
`timescale 1ns/1ps

module motion_system_tb;
    import motion_pkg::*;

    logic                        clk;
    logic                        rst_n;
    logic                        async_up_start, async_up_rw, async_up_handshake_1;
    up_byte_t                    uP_data_in, uP_data_out;
    logic                        uP_data_oe, uP_ack, uP_handshake_2, uP_nFault;
    logic [NOS_QE_CHANNELS-1:0]  quadrature_a, quadrature_b, quadrature_i;
    logic [NOS_PWM_CHANNELS-1:0] pwm_out, h_bridge_1, h_bridge_2;

    // gray phase per encoder in order 00 01 11 10
    int          phase [NOS_QE_CHANNELS];
    // model of the encoder registers
    reg_data_t   exp_pos [NOS_QE_CHANNELS];
    reg_data_t   exp_idx [NOS_QE_CHANNELS];
    int unsigned seed_val;

    `include "motion_tasks.svh"

    motion_system dut0 (
        .CLOCK_50(clk), .rst_n(rst_n),
        .async_up_start(async_up_start), .async_up_rw(async_up_rw),
        .async_up_handshake_1(async_up_handshake_1),
        .uP_data_in(uP_data_in), .uP_data_out(uP_data_out), .uP_data_oe(uP_data_oe),
        .uP_ack(uP_ack), .uP_handshake_2(uP_handshake_2), .uP_nFault(uP_nFault),
        .quadrature_a(quadrature_a), .quadrature_b(quadrature_b),
        .quadrature_i(quadrature_i),
        .pwm_out(pwm_out), .h_bridge_1(h_bridge_1), .h_bridge_2(h_bridge_2)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // encoder pins from the gray phase
    task automatic set_pins(input int ch);
        quadrature_a[ch] = (phase[ch] >= 2);
        quadrature_b[ch] = (phase[ch] == 1) || (phase[ch] == 2);
        next_cycle();
        next_cycle();
    endtask

    // forward is the phase order above
    task automatic step_encoder(input int ch, input bit up);
        phase[ch] = up ? (phase[ch] + 1) % 4 : (phase[ch] + 3) % 4;
        exp_pos[ch] = up ? exp_pos[ch] + 1 : exp_pos[ch] - 1;
        set_pins(ch);
    endtask

    task automatic index_pulse(input int ch);
        quadrature_i[ch] = 1'b1;
        next_cycle();
        next_cycle();
        quadrature_i[ch] = 1'b0;
        next_cycle();
        next_cycle();
        exp_idx[ch] = exp_idx[ch] + 1;
    endtask

    task automatic read_encoder(input int ch);
        reg_data_t rd;
        // pin to register takes 3 clocks
        repeat (4) next_cycle();
        host_read({GROUP_QE, 2'(ch), QE_REG_COUNT}, rd);
        check_data($sformatf("qe%0d position", ch), exp_pos[ch], rd);
        host_read({GROUP_QE, 2'(ch), QE_REG_INDEX}, rd);
        check_data($sformatf("qe%0d index_count", ch), exp_idx[ch], rd);
    endtask

    task automatic reset_and_identity();
        reg_data_t rd;
        check_bit("uP_handshake_2", 1'b0, uP_handshake_2);
        check_bit("uP_ack", 1'b0, uP_ack);
        check_bit("uP_data_oe", 1'b0, uP_data_oe);
        check_bit("uP_nFault", 1'b1, uP_nFault);
        for (int p = 0; p < NOS_PWM_CHANNELS; p++) begin
            check_bit($sformatf("pwm_out[%0d]", p), 1'b0, pwm_out[p]);
            check_bit($sformatf("h_bridge_1[%0d]", p), 1'b0, h_bridge_1[p]);
            check_bit($sformatf("h_bridge_2[%0d]", p), 1'b0, h_bridge_2[p]);
        end
        host_read(8'h00, rd);
        check_data("sys_id", SYS_ID, rd);
    endtask

    task automatic encoder_counting();
        int        steps;
        int        pulses;
        reg_data_t load;
        for (int ch = 0; ch < NOS_QE_CHANNELS; ch++) begin
            steps = $urandom_range(20, 5);
            pulses = $urandom_range(4, 1);
            for (int i = 0; i < steps; i++) begin
                step_encoder(ch, 1'($urandom_range(1, 0)));
            end
            for (int i = 0; i < pulses; i++) begin
                index_pulse(ch);
            end
            read_encoder(ch);
            // load position then clear index
            load = $urandom;
            host_write({GROUP_QE, 2'(ch), QE_REG_COUNT}, load);
            exp_pos[ch] = load;
            host_write({GROUP_QE, 2'(ch), QE_REG_INDEX}, $urandom);
            exp_idx[ch] = '0;
            read_encoder(ch);
        end
    endtask

    task automatic encoder_glitch();
        for (int ch = 0; ch < NOS_QE_CHANNELS; ch++) begin
            // both pins flip together twice
            phase[ch] = (phase[ch] + 2) % 4;
            set_pins(ch);
            phase[ch] = (phase[ch] + 2) % 4;
            set_pins(ch);
            read_encoder(ch);
        end
    endtask

    task automatic pwm_output();
        int        period;
        int        on_time;
        int        ctrl;
        int        high;
        reg_data_t rd;
        for (int ch = 0; ch < NOS_PWM_CHANNELS; ch++) begin
            period = $urandom_range(40, 4);
            on_time = $urandom_range(period, 0);
            ctrl = $urandom_range(3, 0);
            // readback drops the junk upper bits
            host_write({GROUP_PWM, 2'(ch), PWM_REG_PERIOD}, {16'($urandom), 16'(period)});
            host_write({GROUP_PWM, 2'(ch), PWM_REG_ON_TIME}, {16'($urandom), 16'(on_time)});
            host_write({GROUP_PWM, 2'(ch), PWM_REG_CONTROL}, {30'($urandom), 2'(ctrl)});
            host_read({GROUP_PWM, 2'(ch), PWM_REG_PERIOD}, rd);
            check_data($sformatf("pwm%0d period", ch), reg_data_t'(period), rd);
            host_read({GROUP_PWM, 2'(ch), PWM_REG_ON_TIME}, rd);
            check_data($sformatf("pwm%0d on_time", ch), reg_data_t'(on_time), rd);
            host_read({GROUP_PWM, 2'(ch), PWM_REG_CONTROL}, rd);
            check_data($sformatf("pwm%0d control", ch), reg_data_t'(ctrl), rd);
            // any window of one period holds on_time high cycles
            high = 0;
            for (int i = 0; i < period; i++) begin
                next_cycle();
                high += pwm_out[ch];
            end
            check_data($sformatf("pwm_out[%0d] high cycles", ch),
                       reg_data_t'(ctrl[0] ? on_time : 0), reg_data_t'(high));
            check_bit($sformatf("h_bridge_1[%0d]", ch), ctrl[0] && !ctrl[1], h_bridge_1[ch]);
            check_bit($sformatf("h_bridge_2[%0d]", ch), ctrl[0] && ctrl[1], h_bridge_2[ch]);
        end
    endtask

    task automatic fault_recovery();
        reg_data_t rd;
        // group 3 holds nothing
        host_read(8'h37, rd);
        check_data("unmapped read data", '0, rd);
        check_bit("uP_nFault", 1'b0, uP_nFault);
        // identity register is read only
        host_write(8'h00, $urandom);
        check_bit("uP_nFault", 1'b0, uP_nFault);
        host_read(8'h00, rd);
        check_bit("uP_nFault", 1'b1, uP_nFault);
        check_data("sys_id", SYS_ID, rd);
    endtask

    initial begin
        seed_val = 32'ha0dc;
        void'($urandom(seed_val));
        clk = 1'b0;
        rst_n = 1'b0;
        async_up_start = 1'b0;
        async_up_rw = 1'b0;
        async_up_handshake_1 = 1'b0;
        uP_data_in = '0;
        quadrature_a = '0;
        quadrature_b = '0;
        quadrature_i = '0;
        for (int ch = 0; ch < NOS_QE_CHANNELS; ch++) begin
            phase[ch] = 0;
            exp_pos[ch] = '0;
            exp_idx[ch] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        reset_and_identity();
        encoder_counting();
        encoder_glitch();
        pwm_output();
        fault_recovery();
        $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
hw/motion_pkg.sv
hw/synchronizer.sv
hw/up_interface.sv
hw/qe_channel.sv
hw/pwm_channel.sv
hw/motion_system.sv
verification/motion_system_tb.sv
